/* common/vb_pkg.sv */
// victim buffer shared definitions
package vb_pkg;

  //====================
  // widths
  //====================
  localparam int LINE_W    = 512;
  localparam int HALF_W    = 256;
  localparam int BEAT_W    = 128;
  localparam int BEATS     = 4;
  localparam int ADDR_ID_W = 2;

  //====================
  // entry state
  //====================
  // top bit set in every state that holds a line
  typedef enum logic [3:0] {
    IDLE            = 4'b0000,
    GET_VB_DATA     = 4'b1000,
    REQ_WRITE_ADDR  = 4'b1001,
    REQ_WRITE_DATA  = 4'b1010,
    GRNT_WRITE_DATA = 4'b1011
  } vb_state_e;

  // one cache line seen by the fill side and by the write side
  typedef union packed {
    logic [1:0][HALF_W-1:0]       half;
    logic [BEATS-1:0][BEAT_W-1:0] beat;
  } vb_line_u;

  // one-hot beat select
  typedef logic [BEATS-1:0] beat_sel_t;

endpackage

/* common/vb_wd_if.sv */
// entry to arbiter write channel
`timescale 1ns/1ps

interface vb_wd_if;
  import vb_pkg::*;

  // requests from the entry
  logic              req_addr;
  logic              req_data;
  logic [BEAT_W-1:0] line_data;

  // responses from the arbiter
  logic              addr_grant;
  logic              data_grant;
  beat_sel_t         beat_sel;
  logic              pop;

  modport entry (
    output req_addr,
    output req_data,
    output line_data,
    input  addr_grant,
    input  data_grant,
    input  beat_sel,
    input  pop
  );

  modport arbiter (
    input  req_addr,
    input  req_data,
    input  line_data,
    output addr_grant,
    output data_grant,
    output beat_sel,
    output pop
  );

endinterface

/* vb_entry/vb_line_buf.sv */
// victim line buffer
`timescale 1ns/1ps

module vb_line_buf (
  input  logic                        vb_data_entry_clk,
  input  logic                        cpurst_b,
  input  logic                        create_vld,
  input  logic                        fill_vld,
  input  logic [vb_pkg::HALF_W-1:0]   fill_data,
  input  vb_pkg::beat_sel_t           beat_sel,
  output logic                        line_full,
  output logic [vb_pkg::BEAT_W-1:0]   beat_data
);
  import vb_pkg::*;

  vb_line_u   line_q;
  logic [1:0] bias;

  //====================
  // fill bias
  //====================
  // bit 0 points at the low half, bit 1 at the high half
  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bias <= 2'b01;
    else if (create_vld)
      bias <= 2'b01;
    else if (fill_vld)
      bias <= {bias[0], bias[1]};
  end

  //====================
  // line data
  //====================
  always_ff @(posedge vb_data_entry_clk)
  begin
    if (fill_vld && bias[0])
      line_q.half[0] <= fill_data;
    if (fill_vld && bias[1])
      line_q.half[1] <= fill_data;
  end

  // second half completes the line
  assign line_full = fill_vld && bias[1];

  // and-or mux over the beat view
  always_comb
  begin
    beat_data = '0;
    for (int b = 0; b < BEATS; b++)
    begin
      beat_data = beat_data | ({BEAT_W{beat_sel[b]}} & line_q.beat[b]);
    end
  end

endmodule

/* vb_entry/vb_data_entry.sv */
// victim buffer data entry
`timescale 1ns/1ps

module vb_data_entry (
  input  logic                           vb_data_entry_clk,
  input  logic                           cpurst_b,
  input  logic                           create_vld,
  input  logic                           create_dirty,
  input  logic [vb_pkg::ADDR_ID_W-1:0]   create_addr_id,
  input  logic                           fill_vld,
  input  logic [vb_pkg::HALF_W-1:0]      fill_data,
  output logic                           entry_vld,
  output logic                           dirty,
  output logic [vb_pkg::ADDR_ID_W-1:0]   addr_id,
  vb_wd_if.entry                         wd
);
  import vb_pkg::*;

  vb_state_e          state;
  vb_state_e          next_state;
  logic               line_full;
  logic [BEAT_W-1:0]  beat_data;

  //====================
  // line storage
  //====================
  vb_line_buf u_line_buf (
    .vb_data_entry_clk (vb_data_entry_clk),
    .cpurst_b          (cpurst_b),
    .create_vld        (create_vld),
    .fill_vld          (fill_vld),
    .fill_data         (fill_data),
    .beat_sel          (wd.beat_sel),
    .line_full         (line_full),
    .beat_data         (beat_data)
  );

  //====================
  // state register
  //====================
  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= IDLE;
    else
      state <= next_state;
  end

  // eviction flow
  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        if (create_vld)
          next_state = GET_VB_DATA;
      end
      GET_VB_DATA:
      begin
        // leave once the high half lands
        if (line_full)
          next_state = REQ_WRITE_ADDR;
      end
      REQ_WRITE_ADDR:
      begin
        if (wd.addr_grant)
          next_state = REQ_WRITE_DATA;
      end
      REQ_WRITE_DATA:
      begin
        if (wd.data_grant)
          next_state = GRNT_WRITE_DATA;
      end
      GRNT_WRITE_DATA:
      begin
        // pop comes with the last accepted beat
        if (wd.pop)
          next_state = IDLE;
      end
      default:
        next_state = IDLE;
    endcase
  end

  //====================
  // attributes
  //====================
  // captured once per eviction
  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dirty   <= 1'b0;
      addr_id <= '0;
    end
    else if (create_vld)
    begin
      dirty   <= create_dirty;
      addr_id <= create_addr_id;
    end
  end

  // requests come straight from state
  assign entry_vld    = state[3];
  assign wd.req_addr  = (state == REQ_WRITE_ADDR);
  assign wd.req_data  = (state == REQ_WRITE_DATA);
  assign wd.line_data = beat_data;

endmodule

/* logic/vb_wd_arbiter.sv */
// write address and data arbiter
`timescale 1ns/1ps

module vb_wd_arbiter #(
  parameter  int NUM_ENTRIES = 2,
  localparam int ID_W        = $clog2(NUM_ENTRIES)
) (
  input  logic                                        vb_data_entry_clk,
  input  logic                                        cpurst_b,
  input  logic                                        biu_grant,
  input  logic                                        wd_ready,
  input  logic [NUM_ENTRIES-1:0]                      entry_dirty,
  input  logic [NUM_ENTRIES-1:0][vb_pkg::ADDR_ID_W-1:0] entry_addr_id,
  output logic                                        biu_req,
  output logic [ID_W-1:0]                             biu_req_id,
  output logic                                        biu_req_dirty,
  output logic [vb_pkg::ADDR_ID_W-1:0]                biu_req_addr_id,
  output logic                                        wd_vld,
  output logic [ID_W-1:0]                             wd_id,
  output logic [vb_pkg::BEAT_W-1:0]                   wd_data,
  output logic                                        wd_last,
  vb_wd_if.arbiter                                    wd [NUM_ENTRIES]
);
  import vb_pkg::*;

  logic [NUM_ENTRIES-1:0] addr_req;
  logic [NUM_ENTRIES-1:0] data_req;
  logic [NUM_ENTRIES-1:0] entry_pop;
  logic [BEAT_W-1:0]      beat_data [NUM_ENTRIES];
  logic [ID_W-1:0]        addr_ptr;
  logic [ID_W-1:0]        addr_sel;
  logic                   addr_lock;
  logic [ID_W-1:0]        addr_lock_id;
  logic [ID_W-1:0]        data_ptr;
  logic [ID_W-1:0]        data_pick;
  logic                   data_busy;
  logic [ID_W-1:0]        data_owner;
  beat_sel_t              beat_q;
  logic                   data_start;
  logic                   beat_xfer;
  logic                   last_xfer;

  // first requester at or after ptr
  function automatic logic [ID_W-1:0] rr_pick(input logic [NUM_ENTRIES-1:0] req,
                                               input logic [ID_W-1:0] ptr);
    int              idx;
    logic [ID_W-1:0] pick;
    logic            found;
    pick  = ptr;
    found = 1'b0;
    for (int k = 0; k < NUM_ENTRIES; k++)
    begin
      idx = (int'(ptr) + k) % NUM_ENTRIES;
      if (!found && req[idx])
      begin
        pick  = ID_W'(idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic logic [ID_W-1:0] next_id(input logic [ID_W-1:0] id);
    return (int'(id) == NUM_ENTRIES - 1) ? '0 : id + 1'b1;
  endfunction

  //====================
  // address channel
  //====================
  // a stalled request keeps its id until granted
  assign addr_sel        = addr_lock ? addr_lock_id : rr_pick(addr_req, addr_ptr);
  assign biu_req         = |addr_req;
  assign biu_req_id      = addr_sel;
  assign biu_req_dirty   = entry_dirty[addr_sel];
  assign biu_req_addr_id = entry_addr_id[addr_sel];

  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      addr_ptr     <= '0;
      addr_lock    <= 1'b0;
      addr_lock_id <= '0;
    end
    else if (biu_req && biu_grant)
    begin
      addr_ptr  <= next_id(addr_sel);
      addr_lock <= 1'b0;
    end
    else if (biu_req)
    begin
      addr_lock    <= 1'b1;
      addr_lock_id <= addr_sel;
    end
  end

  //====================
  // data sequencer
  //====================
  assign data_pick  = rr_pick(data_req, data_ptr);
  assign data_start = !data_busy && (|data_req);
  assign beat_xfer  = data_busy && wd_ready;
  assign last_xfer  = beat_xfer && beat_q[BEATS-1];

  always_ff @(posedge vb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      data_busy  <= 1'b0;
      data_owner <= '0;
      data_ptr   <= '0;
      beat_q     <= '0;
    end
    else if (data_start)
    begin
      data_busy  <= 1'b1;
      data_owner <= data_pick;
      data_ptr   <= next_id(data_pick);
      beat_q     <= beat_sel_t'(1);
    end
    else if (last_xfer)
    begin
      // channel frees up on the following cycle
      data_busy <= 1'b0;
      beat_q    <= '0;
    end
    else if (beat_xfer)
      beat_q <= {beat_q[BEATS-2:0], 1'b0};
  end

  assign wd_vld  = data_busy;
  assign wd_id   = data_owner;
  assign wd_data = beat_data[data_owner];
  assign wd_last = beat_q[BEATS-1];

  //====================
  // per entry wiring
  //====================
  for (genvar i = 0; i < NUM_ENTRIES; i++)
  begin : g_port
    assign addr_req[i]     = wd[i].req_addr;
    assign data_req[i]     = wd[i].req_data;
    assign beat_data[i]    = wd[i].line_data;
    assign entry_pop[i]    = last_xfer && (data_owner == ID_W'(i));
    assign wd[i].addr_grant = biu_req && biu_grant && (addr_sel == ID_W'(i));
    assign wd[i].data_grant = data_start && (data_pick == ID_W'(i));
    assign wd[i].pop       = entry_pop[i];
    // only the owner sees a live beat select
    assign wd[i].beat_sel  = (data_busy && data_owner == ID_W'(i)) ? beat_q : '0;
  end

endmodule

/* logic/vb_top.sv */
// victim write-back buffer top
`timescale 1ns/1ps

module vb_top #(
  parameter  int NUM_ENTRIES = 2,
  localparam int ID_W        = $clog2(NUM_ENTRIES)
) (
  input  logic                          vb_data_entry_clk,
  input  logic                          cpurst_b,
  input  logic                          create_vld,
  input  logic [ID_W-1:0]               create_id,
  input  logic                          create_dirty,
  input  logic [vb_pkg::ADDR_ID_W-1:0]  create_addr_id,
  input  logic                          fill_vld,
  input  logic [ID_W-1:0]               fill_id,
  input  logic [vb_pkg::HALF_W-1:0]     fill_data,
  input  logic                          biu_grant,
  input  logic                          wd_ready,
  output logic [NUM_ENTRIES-1:0]        entry_vld,
  output logic                          biu_req,
  output logic [ID_W-1:0]               biu_req_id,
  output logic                          biu_req_dirty,
  output logic [vb_pkg::ADDR_ID_W-1:0]  biu_req_addr_id,
  output logic                          wd_vld,
  output logic [ID_W-1:0]               wd_id,
  output logic [vb_pkg::BEAT_W-1:0]     wd_data,
  output logic                          wd_last
);
  import vb_pkg::*;

  logic [NUM_ENTRIES-1:0]                entry_create;
  logic [NUM_ENTRIES-1:0]                entry_fill;
  logic [NUM_ENTRIES-1:0]                entry_dirty;
  logic [NUM_ENTRIES-1:0][ADDR_ID_W-1:0] entry_addr_id;

  vb_wd_if wd_if [NUM_ENTRIES] ();

  //====================
  // entries
  //====================
  for (genvar i = 0; i < NUM_ENTRIES; i++)
  begin : g_entry
    // id decode to per entry strobes
    assign entry_create[i] = create_vld && (create_id == ID_W'(i));
    assign entry_fill[i]   = fill_vld && (fill_id == ID_W'(i));

    vb_data_entry u_entry (
      .vb_data_entry_clk (vb_data_entry_clk),
      .cpurst_b          (cpurst_b),
      .create_vld        (entry_create[i]),
      .create_dirty      (create_dirty),
      .create_addr_id    (create_addr_id),
      .fill_vld          (entry_fill[i]),
      .fill_data         (fill_data),
      .entry_vld         (entry_vld[i]),
      .dirty             (entry_dirty[i]),
      .addr_id           (entry_addr_id[i]),
      .wd                (wd_if[i])
    );
  end

  //====================
  // shared channels
  //====================
  vb_wd_arbiter #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_arbiter (
    .vb_data_entry_clk (vb_data_entry_clk),
    .cpurst_b          (cpurst_b),
    .biu_grant         (biu_grant),
    .wd_ready          (wd_ready),
    .entry_dirty       (entry_dirty),
    .entry_addr_id     (entry_addr_id),
    .biu_req           (biu_req),
    .biu_req_id        (biu_req_id),
    .biu_req_dirty     (biu_req_dirty),
    .biu_req_addr_id   (biu_req_addr_id),
    .wd_vld            (wd_vld),
    .wd_id             (wd_id),
    .wd_data           (wd_data),
    .wd_last           (wd_last),
    .wd                (wd_if)
  );

endmodule

/* verification/vb_wd_checker.sv */
// write channel protocol checker
`timescale 1ns/1ps

module vb_wd_checker (
  input logic                      vb_data_entry_clk,
  input logic                      cpurst_b,
  input logic                      wd_vld,
  input logic                      wd_ready,
  input logic                      wd_last,
  input logic [vb_pkg::BEAT_W-1:0] wd_data,
  input logic                      pop_onehot0,
  input logic                      biu_req,
  input logic                      biu_grant,
  input logic [3:0]                req_id
);

  // beat held while the sink stalls
  a_data_stable : assert property (@(posedge vb_data_entry_clk) disable iff (!cpurst_b)
    wd_vld && !wd_ready |=> $stable(wd_data))
  else $error("wd_data changed while wd_ready was low");

  a_last_in_vld : assert property (@(posedge vb_data_entry_clk) disable iff (!cpurst_b)
    wd_last |-> wd_vld)
  else $error("wd_last high without wd_vld");

  a_one_pop : assert property (@(posedge vb_data_entry_clk) disable iff (!cpurst_b)
    pop_onehot0)
  else $error("more than one entry popped in one cycle");

  // stalled address request keeps its id
  a_req_id_stable : assert property (@(posedge vb_data_entry_clk) disable iff (!cpurst_b)
    biu_req && !biu_grant |=> $stable(req_id))
  else $error("biu_req_id changed while biu_grant was low");

endmodule

bind vb_wd_arbiter vb_wd_checker u_wd_checker (
  .vb_data_entry_clk (vb_data_entry_clk),
  .cpurst_b          (cpurst_b),
  .wd_vld            (wd_vld),
  .wd_ready          (wd_ready),
  .wd_last           (wd_last),
  .wd_data           (wd_data),
  .pop_onehot0       ($onehot0(entry_pop)),
  .biu_req           (biu_req),
  .biu_grant         (biu_grant),
  .req_id            (4'(biu_req_id))
);

/* verification/vb_tb.sv */
// victim buffer testbench
`timescale 1ns/1ps

module vb_tb;
  import vb_pkg::*;

  localparam int NUM_ENTRIES = 2;
  localparam int ID_W        = 1;
  localparam int EVICTIONS   = 40;
  localparam int CYCLE_LIMIT = EVICTIONS * 64;

  logic                   vb_data_entry_clk;
  logic                   cpurst_b;
  logic                   create_vld;
  logic [ID_W-1:0]        create_id;
  logic                   create_dirty;
  logic [ADDR_ID_W-1:0]   create_addr_id;
  logic                   fill_vld;
  logic [ID_W-1:0]        fill_id;
  logic [HALF_W-1:0]      fill_data;
  logic                   biu_grant;
  logic                   wd_ready;
  logic [NUM_ENTRIES-1:0] entry_vld;
  logic                   biu_req;
  logic [ID_W-1:0]        biu_req_id;
  logic                   biu_req_dirty;
  logic [ADDR_ID_W-1:0]   biu_req_addr_id;
  logic                   wd_vld;
  logic [ID_W-1:0]        wd_id;
  logic [BEAT_W-1:0]      wd_data;
  logic                   wd_last;

  //====================
  // model state
  //====================
  // phase 0 idle, 1 filling, 2 address wait, 3 data wait, 4 bursting
  int                   phase [NUM_ENTRIES];
  int                   fills [NUM_ENTRIES];
  logic [LINE_W-1:0]    exp_line [NUM_ENTRIES];
  logic                 exp_dirty [NUM_ENTRIES];
  logic [ADDR_ID_W-1:0] exp_addr_id [NUM_ENTRIES];
  logic [31:0]          lfsr;
  logic                 addr_lock;
  logic                 data_busy;
  int                   addr_ptr;
  int                   lock_id;
  int                   data_ptr;
  int                   owner;
  int                   beat;
  int                   created;
  int                   retired;
  int                   cycles;
  int                   mismatches;
  int                   failures;

  vb_top #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) dut0 (
    .vb_data_entry_clk (vb_data_entry_clk),
    .cpurst_b          (cpurst_b),
    .create_vld        (create_vld),
    .create_id         (create_id),
    .create_dirty      (create_dirty),
    .create_addr_id    (create_addr_id),
    .fill_vld          (fill_vld),
    .fill_id           (fill_id),
    .fill_data         (fill_data),
    .biu_grant         (biu_grant),
    .wd_ready          (wd_ready),
    .entry_vld         (entry_vld),
    .biu_req           (biu_req),
    .biu_req_id        (biu_req_id),
    .biu_req_dirty     (biu_req_dirty),
    .biu_req_addr_id   (biu_req_addr_id),
    .wd_vld            (wd_vld),
    .wd_id             (wd_id),
    .wd_data           (wd_data),
    .wd_last           (wd_last)
  );

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // first entry in the wanted phase at or after ptr or -1 if none
  function automatic int pick_from(input int want, input int ptr);
    int idx;
    for (int k = 0; k < NUM_ENTRIES; k++)
    begin
      idx = (ptr + k) % NUM_ENTRIES;
      if (phase[idx] == want)
        return idx;
    end
    return -1;
  endfunction

  task automatic report_mismatch(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
    $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
    mismatches++;
  endtask

  initial
  begin
    vb_data_entry_clk = 1'b0;
    forever #4 vb_data_entry_clk = ~vb_data_entry_clk;
  end

  always @(posedge vb_data_entry_clk)
  begin
    if (cpurst_b)
      cycles <= cycles + 1;
  end

  //====================
  // stimulus
  //====================
  always @(posedge vb_data_entry_clk)
  begin
    logic [31:0]       r_create;
    logic [31:0]       r_fill;
    logic [31:0]       r_hs;
    logic [HALF_W-1:0] data;
    logic              do_create;
    if (cpurst_b)
    begin
      r_create  = rand_bits(6);
      r_fill    = rand_bits(2);
      for (int w = 0; w < HALF_W / 32; w++)
        data[w*32 +: 32] = rand_bits(32);
      r_hs      = rand_bits(2);
      // create into a free entry about one cycle in four
      do_create = (r_create[5:4] == 2'b00) && (created < EVICTIONS)
                  && (phase[r_create[3]] == 0);
      if (do_create)
        created++;
      create_vld     <= do_create;
      create_id      <= r_create[3];
      create_dirty   <= r_create[2];
      create_addr_id <= r_create[1:0];
      fill_vld       <= r_fill[1] && (phase[r_fill[0]] == 1) && (fills[r_fill[0]] > 0);
      fill_id        <= r_fill[0];
      fill_data      <= data;
      biu_grant      <= r_hs[1];
      wd_ready       <= r_hs[0];
    end
  end

  //====================
  // model and checks
  //====================
  always @(negedge vb_data_entry_clk)
  begin
    logic [NUM_ENTRIES-1:0] vld_exp;
    int                     a_id;
    int                     d_id;
    int                     h;
    if (cpurst_b)
    begin
      for (int e = 0; e < NUM_ENTRIES; e++)
        vld_exp[e] = (phase[e] != 0);
      if (entry_vld !== vld_exp)
        report_mismatch("entry_vld", entry_vld, vld_exp);
      if (wd_vld !== data_busy)
        report_mismatch("wd_vld", wd_vld, data_busy);
      // data channel goes first since it sees last cycle's requesters
      if (data_busy)
      begin
        if (wd_id !== ID_W'(owner))
          report_mismatch("wd_id", wd_id, owner);
        if (wd_data !== exp_line[owner][beat*BEAT_W +: BEAT_W])
          report_mismatch("wd_data", wd_data, exp_line[owner][beat*BEAT_W +: BEAT_W]);
        if (wd_last !== (beat == BEATS - 1))
          report_mismatch("wd_last", wd_last, beat == BEATS - 1);
        if (wd_ready && beat == BEATS - 1)
        begin
          data_busy    = 1'b0;
          phase[owner] = 0;
          retired++;
        end
        else if (wd_ready)
          beat++;
      end
      else
      begin
        if (wd_last !== 1'b0)
          report_mismatch("wd_last", wd_last, 1'b0);
        d_id = pick_from(3, data_ptr);
        if (d_id >= 0)
        begin
          data_busy   = 1'b1;
          owner       = d_id;
          beat        = 0;
          data_ptr    = (d_id + 1) % NUM_ENTRIES;
          phase[d_id] = 4;
        end
      end
      // address channel
      a_id = addr_lock ? lock_id : pick_from(2, addr_ptr);
      if (biu_req !== (a_id >= 0))
        report_mismatch("biu_req", biu_req, a_id >= 0);
      if (a_id >= 0)
      begin
        if (biu_req_id !== ID_W'(a_id))
          report_mismatch("biu_req_id", biu_req_id, a_id);
        if (biu_req_dirty !== exp_dirty[a_id])
          report_mismatch("biu_req_dirty", biu_req_dirty, exp_dirty[a_id]);
        if (biu_req_addr_id !== exp_addr_id[a_id])
          report_mismatch("biu_req_addr_id", biu_req_addr_id, exp_addr_id[a_id]);
        addr_lock = !biu_grant;
        lock_id   = a_id;
        if (biu_grant)
        begin
          phase[a_id] = 3;
          addr_ptr    = (a_id + 1) % NUM_ENTRIES;
        end
      end
      if (fill_vld)
      begin
        h = 2 - fills[fill_id];
        exp_line[fill_id][h*HALF_W +: HALF_W] = fill_data;
        fills[fill_id]--;
        if (fills[fill_id] == 0)
          phase[fill_id] = 2;
      end
      if (create_vld)
      begin
        phase[create_id]       = 1;
        fills[create_id]       = 2;
        exp_dirty[create_id]   = create_dirty;
        exp_addr_id[create_id] = create_addr_id;
      end
    end
  end

  initial
  begin
    cpurst_b       = 1'b0;
    create_vld     = 1'b0;
    create_id      = '0;
    create_dirty   = 1'b0;
    create_addr_id = '0;
    fill_vld       = 1'b0;
    fill_id        = '0;
    fill_data      = '0;
    biu_grant      = 1'b0;
    wd_ready       = 1'b0;
    lfsr           = 32'd98;
    addr_lock      = 1'b0;
    data_busy      = 1'b0;
    addr_ptr       = 0;
    lock_id        = 0;
    data_ptr       = 0;
    owner          = 0;
    beat           = 0;
    created        = 0;
    retired        = 0;
    cycles         = 0;
    mismatches     = 0;
    failures       = 0;
    for (int e = 0; e < NUM_ENTRIES; e++)
    begin
      phase[e] = 0;
      fills[e] = 0;
    end
    repeat (16) @(posedge vb_data_entry_clk);
    cpurst_b <= 1'b1;
    while (retired < EVICTIONS && cycles < CYCLE_LIMIT)
      @(posedge vb_data_entry_clk);
    if (retired < EVICTIONS)
    begin
      $display("timeout after %0d cycles with %0d of %0d evictions done",
               cycles, retired, EVICTIONS);
      failures++;
    end
    $display("summary: %0d mismatches, %0d other errors, %0d evictions",
             mismatches, failures, retired);
    if (mismatches == 0 && failures == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* vb_wd.f */
common/vb_pkg.sv
common/vb_wd_if.sv
vb_entry/vb_line_buf.sv
vb_entry/vb_data_entry.sv
logic/vb_wd_arbiter.sv
logic/vb_top.sv
verification/vb_wd_checker.sv
verification/vb_tb.sv
